/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // Architectural widths, data width stays at 32 for the signed compares
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 8;

    // Register index, rs1, rs2 and rd all use it
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Register value and operand
    typedef logic [XLEN-1:0] reg_data_t;

    // ALU operation code, opaque to dispatch
    typedef logic [ALU_OP_W-1:0] alu_op_t;

    // Immediate, already sign or zero extended by decode
    typedef logic [XLEN-1:0] imm_t;

endpackage

`default_nettype wire

/* source/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

    localparam int NUM_BR_FLAGS = 6;

    // One bit per lane, bit 0 is the older instruction
    typedef logic [1:0] issue_mask_t;

    // Precomputed branch compare results
    typedef logic [NUM_BR_FLAGS-1:0] branch_flags_t;

    // Flag positions inside branch_flags_t
    localparam int BR_EQ  = 0;
    localparam int BR_NE  = 1;
    // Signed compares
    localparam int BR_LT  = 2;
    localparam int BR_GE  = 3;
    // Unsigned compares
    localparam int BR_LTU = 4;
    localparam int BR_GEU = 5;

endpackage

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file
    import isa_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic                clk,
    input  logic                rst_n,

    // Read ports, order is lane0 rs1, lane0 rs2, lane1 rs1, lane1 rs2
    input  reg_addr_t [3:0]     rd_addr_i,
    output reg_data_t [3:0]     rd_data_o,

    // Write ports from the memory stage, port 1 is the younger one
    input  logic      [1:0]     we_i,
    input  reg_addr_t [1:0]     wr_addr_i,
    input  reg_data_t [1:0]     wr_data_i
);

    localparam int IDX_W = $clog2(NUM_REGS);

    reg_data_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Port 1 is applied last so it wins a collision
            for (int p = 0; p < 2; p++) begin
                if (we_i[p] && wr_addr_i[p] != '0 && int'(wr_addr_i[p]) < NUM_REGS) begin
                    regs[wr_addr_i[p][IDX_W-1:0]] <= wr_data_i[p];
                end
            end
        end
    end

    // Combinational reads, no write-through
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            if (rd_addr_i[r] == '0 || int'(rd_addr_i[r]) >= NUM_REGS) begin
                // x0 is hardwired, out of range indices read as zero too
                rd_data_o[r] = '0;
            end else begin
                rd_data_o[r] = regs[rd_addr_i[r][IDX_W-1:0]];
            end
        end
    end

endmodule

`default_nettype wire

/* source/issue_hazard.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_hazard
    import isa_pkg::*;
    import dispatch_pkg::*;
(
    // Destination of the older instruction
    input  reg_addr_t   lane0_rd_addr_i,
    input  logic        lane0_rd_we_i,

    // Sources of the younger instruction
    input  reg_addr_t   lane1_rs1_addr_i,
    input  logic        lane1_rs1_rd_i,
    input  reg_addr_t   lane1_rs2_addr_i,
    input  logic        lane1_rs2_rd_i,

    output issue_mask_t issue_mask_o
);

    logic rs1_dep;
    logic rs2_dep;

    // RAW inside the pair, x0 is not filtered here
    assign rs1_dep = lane0_rd_we_i && lane1_rs1_rd_i &&
                     (lane1_rs1_addr_i == lane0_rd_addr_i);
    assign rs2_dep = lane0_rd_we_i && lane1_rs2_rd_i &&
                     (lane1_rs2_addr_i == lane0_rd_addr_i);

    // Lane 0 never waits on lane 1
    assign issue_mask_o = {~(rs1_dep | rs2_dep), 1'b1};

endmodule

`default_nettype wire

/* source/operand_select.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_select
    import isa_pkg::*;
    import dispatch_pkg::*;
(
    // Lane 0
    input  reg_addr_t     lane0_rs1_addr_i,
    input  logic          lane0_rs1_rd_i,
    input  reg_addr_t     lane0_rs2_addr_i,
    input  logic          lane0_rs2_rd_i,
    input  logic          lane0_use_imm_i,
    input  imm_t          lane0_imm_i,
    input  reg_data_t     lane0_rf_rs1_data_i,
    input  reg_data_t     lane0_rf_rs2_data_i,

    // Lane 1
    input  reg_addr_t     lane1_rs1_addr_i,
    input  logic          lane1_rs1_rd_i,
    input  reg_addr_t     lane1_rs2_addr_i,
    input  logic          lane1_rs2_rd_i,
    input  logic          lane1_use_imm_i,
    input  imm_t          lane1_imm_i,
    input  reg_data_t     lane1_rf_rs1_data_i,
    input  reg_data_t     lane1_rf_rs2_data_i,

    // Forwarding from execute and memory
    input  logic          ex0_fwd_we_i,
    input  reg_addr_t     ex0_fwd_addr_i,
    input  reg_data_t     ex0_fwd_data_i,
    input  logic          ex1_fwd_we_i,
    input  reg_addr_t     ex1_fwd_addr_i,
    input  reg_data_t     ex1_fwd_data_i,
    input  logic          mem0_fwd_we_i,
    input  reg_addr_t     mem0_fwd_addr_i,
    input  reg_data_t     mem0_fwd_data_i,
    input  logic          mem1_fwd_we_i,
    input  reg_addr_t     mem1_fwd_addr_i,
    input  reg_data_t     mem1_fwd_data_i,

    output reg_data_t     lane0_op1_o,
    output reg_data_t     lane0_op2_o,
    output branch_flags_t lane0_br_flags_o,
    output reg_data_t     lane1_op1_o,
    output reg_data_t     lane1_op2_o,
    output branch_flags_t lane1_br_flags_o
);

    // Forwarding sources, index 0 has the highest priority
    logic      [3:0] src_we;
    reg_addr_t [3:0] src_addr;
    reg_data_t [3:0] src_data;

    // Register operands before immediate selection
    reg_data_t lane0_rs1_val;
    reg_data_t lane0_rs2_val;
    reg_data_t lane1_rs1_val;
    reg_data_t lane1_rs2_val;

    function automatic reg_data_t pick_operand(
        input reg_addr_t       addr,
        input logic            rd_en,
        input reg_data_t       rf_data,
        input logic      [3:0] we,
        input reg_addr_t [3:0] fa,
        input reg_data_t [3:0] fd
    );
        reg_data_t val;
        val = rf_data;
        if (rd_en && addr != '0) begin
            // Lowest priority first, so the best match is written last
            for (int s = 3; s >= 0; s--) begin
                if (we[s] && fa[s] == addr) begin
                    val = fd[s];
                end
            end
        end
        return val;
    endfunction

    function automatic branch_flags_t compare_flags(input reg_data_t a, input reg_data_t b);
        branch_flags_t f;
        f[BR_EQ]  = (a == b);
        f[BR_NE]  = (a != b);
        f[BR_LT]  = ($signed(a) < $signed(b));
        f[BR_GE]  = ($signed(a) >= $signed(b));
        f[BR_LTU] = (a < b);
        f[BR_GEU] = (a >= b);
        return f;
    endfunction

    assign src_we   = {mem0_fwd_we_i, mem1_fwd_we_i, ex0_fwd_we_i, ex1_fwd_we_i};
    assign src_addr = {mem0_fwd_addr_i, mem1_fwd_addr_i, ex0_fwd_addr_i, ex1_fwd_addr_i};
    assign src_data = {mem0_fwd_data_i, mem1_fwd_data_i, ex0_fwd_data_i, ex1_fwd_data_i};

    assign lane0_rs1_val = pick_operand(lane0_rs1_addr_i, lane0_rs1_rd_i, lane0_rf_rs1_data_i,
                                        src_we, src_addr, src_data);
    assign lane0_rs2_val = pick_operand(lane0_rs2_addr_i, lane0_rs2_rd_i, lane0_rf_rs2_data_i,
                                        src_we, src_addr, src_data);
    assign lane1_rs1_val = pick_operand(lane1_rs1_addr_i, lane1_rs1_rd_i, lane1_rf_rs1_data_i,
                                        src_we, src_addr, src_data);
    assign lane1_rs2_val = pick_operand(lane1_rs2_addr_i, lane1_rs2_rd_i, lane1_rf_rs2_data_i,
                                        src_we, src_addr, src_data);

    assign lane0_op1_o = lane0_rs1_val;
    assign lane1_op1_o = lane1_rs1_val;
    assign lane0_op2_o = lane0_use_imm_i ? lane0_imm_i : lane0_rs2_val;
    assign lane1_op2_o = lane1_use_imm_i ? lane1_imm_i : lane1_rs2_val;

    // Flags always compare rs1 with rs2, even for immediate forms
    assign lane0_br_flags_o = compare_flags(lane0_rs1_val, lane0_rs2_val);
    assign lane1_br_flags_o = compare_flags(lane1_rs1_val, lane1_rs2_val);

endmodule

`default_nettype wire

/* source/dispatch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_stage
    import isa_pkg::*;
    import dispatch_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall_i,
    input  logic          flush_i,
    input  issue_mask_t   issue_mask_i,

    input  logic          lane0_valid_i,
    input  alu_op_t       lane0_alu_op_i,
    input  reg_addr_t     lane0_rd_addr_i,
    input  logic          lane0_rd_we_i,
    input  imm_t          lane0_imm_i,
    input  reg_data_t     lane0_op1_i,
    input  reg_data_t     lane0_op2_i,
    input  branch_flags_t lane0_br_flags_i,

    input  logic          lane1_valid_i,
    input  alu_op_t       lane1_alu_op_i,
    input  reg_addr_t     lane1_rd_addr_i,
    input  logic          lane1_rd_we_i,
    input  imm_t          lane1_imm_i,
    input  reg_data_t     lane1_op1_i,
    input  reg_data_t     lane1_op2_i,
    input  branch_flags_t lane1_br_flags_i,

    output logic [1:0]    accept_o,

    output logic          out0_valid_o,
    output alu_op_t       out0_alu_op_o,
    output reg_addr_t     out0_rd_addr_o,
    output logic          out0_rd_we_o,
    output reg_data_t     out0_op1_o,
    output reg_data_t     out0_op2_o,
    output imm_t          out0_imm_o,
    output branch_flags_t out0_br_flags_o,

    output logic          out1_valid_o,
    output alu_op_t       out1_alu_op_o,
    output reg_addr_t     out1_rd_addr_o,
    output logic          out1_rd_we_o,
    output reg_data_t     out1_op1_o,
    output reg_data_t     out1_op2_o,
    output imm_t          out1_imm_o,
    output branch_flags_t out1_br_flags_o
);

    // Per-lane views of the inputs
    alu_op_t       [1:0] in_alu_op;
    reg_addr_t     [1:0] in_rd_addr;
    logic          [1:0] in_rd_we;
    imm_t          [1:0] in_imm;
    reg_data_t     [1:0] in_op1;
    reg_data_t     [1:0] in_op2;
    branch_flags_t [1:0] in_br_flags;

    // Output register
    logic          [1:0] q_valid;
    alu_op_t       [1:0] q_alu_op;
    reg_addr_t     [1:0] q_rd_addr;
    logic          [1:0] q_rd_we;
    imm_t          [1:0] q_imm;
    reg_data_t     [1:0] q_op1;
    reg_data_t     [1:0] q_op2;
    branch_flags_t [1:0] q_br_flags;

    assign in_alu_op   = {lane1_alu_op_i, lane0_alu_op_i};
    assign in_rd_addr  = {lane1_rd_addr_i, lane0_rd_addr_i};
    assign in_rd_we    = {lane1_rd_we_i, lane0_rd_we_i};
    assign in_imm      = {lane1_imm_i, lane0_imm_i};
    assign in_op1      = {lane1_op1_i, lane0_op1_i};
    assign in_op2      = {lane1_op2_i, lane0_op2_i};
    assign in_br_flags = {lane1_br_flags_i, lane0_br_flags_i};

    // The buffer pops exactly these lanes on the next edge
    assign accept_o = {lane1_valid_i, lane0_valid_i} & issue_mask_i
                    & {2{~(stall_i | flush_i)}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid    <= '0;
            q_alu_op   <= '0;
            q_rd_addr  <= '0;
            q_rd_we    <= '0;
            q_imm      <= '0;
            q_op1      <= '0;
            q_op2      <= '0;
            q_br_flags <= '0;
        end else if (flush_i || !stall_i) begin
            // Flush forces accept low, so it lands in the clear branch
            for (int n = 0; n < 2; n++) begin
                if (accept_o[n]) begin
                    q_valid[n]    <= 1'b1;
                    q_alu_op[n]   <= in_alu_op[n];
                    q_rd_addr[n]  <= in_rd_addr[n];
                    q_rd_we[n]    <= in_rd_we[n];
                    q_imm[n]      <= in_imm[n];
                    q_op1[n]      <= in_op1[n];
                    q_op2[n]      <= in_op2[n];
                    q_br_flags[n] <= in_br_flags[n];
                end else begin
                    q_valid[n]    <= 1'b0;
                    q_alu_op[n]   <= '0;
                    q_rd_addr[n]  <= '0;
                    q_rd_we[n]    <= 1'b0;
                    q_imm[n]      <= '0;
                    q_op1[n]      <= '0;
                    q_op2[n]      <= '0;
                    q_br_flags[n] <= '0;
                end
            end
        end
    end

    assign out0_valid_o    = q_valid[0];
    assign out0_alu_op_o   = q_alu_op[0];
    assign out0_rd_addr_o  = q_rd_addr[0];
    assign out0_rd_we_o    = q_rd_we[0];
    assign out0_op1_o      = q_op1[0];
    assign out0_op2_o      = q_op2[0];
    assign out0_imm_o      = q_imm[0];
    assign out0_br_flags_o = q_br_flags[0];

    assign out1_valid_o    = q_valid[1];
    assign out1_alu_op_o   = q_alu_op[1];
    assign out1_rd_addr_o  = q_rd_addr[1];
    assign out1_rd_we_o    = q_rd_we[1];
    assign out1_op1_o      = q_op1[1];
    assign out1_op2_o      = q_op2[1];
    assign out1_imm_o      = q_imm[1];
    assign out1_br_flags_o = q_br_flags[1];

endmodule

`default_nettype wire

/* source/dispatch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_top
    import isa_pkg::*;
    import dispatch_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic          clk,
    input  logic          rst_n,

    // Decoded pair, lane 0 is older
    input  logic          lane0_valid_i,
    input  reg_addr_t     lane0_rs1_addr_i,
    input  logic          lane0_rs1_rd_i,
    input  reg_addr_t     lane0_rs2_addr_i,
    input  logic          lane0_rs2_rd_i,
    input  reg_addr_t     lane0_rd_addr_i,
    input  logic          lane0_rd_we_i,
    input  alu_op_t       lane0_alu_op_i,
    input  logic          lane0_use_imm_i,
    input  imm_t          lane0_imm_i,

    input  logic          lane1_valid_i,
    input  reg_addr_t     lane1_rs1_addr_i,
    input  logic          lane1_rs1_rd_i,
    input  reg_addr_t     lane1_rs2_addr_i,
    input  logic          lane1_rs2_rd_i,
    input  reg_addr_t     lane1_rd_addr_i,
    input  logic          lane1_rd_we_i,
    input  alu_op_t       lane1_alu_op_i,
    input  logic          lane1_use_imm_i,
    input  imm_t          lane1_imm_i,

    // Execute forwarding
    input  logic          ex0_fwd_we_i,
    input  reg_addr_t     ex0_fwd_addr_i,
    input  reg_data_t     ex0_fwd_data_i,
    input  logic          ex1_fwd_we_i,
    input  reg_addr_t     ex1_fwd_addr_i,
    input  reg_data_t     ex1_fwd_data_i,

    // Memory forwarding, doubles as writeback
    input  logic          mem0_fwd_we_i,
    input  reg_addr_t     mem0_fwd_addr_i,
    input  reg_data_t     mem0_fwd_data_i,
    input  logic          mem1_fwd_we_i,
    input  reg_addr_t     mem1_fwd_addr_i,
    input  reg_data_t     mem1_fwd_data_i,

    input  logic          stall_i,
    input  logic          flush_i,

    output logic [1:0]    accept_o,

    output logic          out0_valid_o,
    output alu_op_t       out0_alu_op_o,
    output reg_addr_t     out0_rd_addr_o,
    output logic          out0_rd_we_o,
    output reg_data_t     out0_op1_o,
    output reg_data_t     out0_op2_o,
    output imm_t          out0_imm_o,
    output branch_flags_t out0_br_flags_o,

    output logic          out1_valid_o,
    output alu_op_t       out1_alu_op_o,
    output reg_addr_t     out1_rd_addr_o,
    output logic          out1_rd_we_o,
    output reg_data_t     out1_op1_o,
    output reg_data_t     out1_op2_o,
    output imm_t          out1_imm_o,
    output branch_flags_t out1_br_flags_o
);

    // Order is lane0 rs1, lane0 rs2, lane1 rs1, lane1 rs2
    reg_data_t [3:0] rf_rd_data;

    issue_mask_t   issue_mask;
    reg_data_t     lane0_op1;
    reg_data_t     lane0_op2;
    branch_flags_t lane0_br_flags;
    reg_data_t     lane1_op1;
    reg_data_t     lane1_op2;
    branch_flags_t lane1_br_flags;

    register_file #(
        .NUM_REGS (NUM_REGS)
    ) u_register_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_i ({lane1_rs2_addr_i, lane1_rs1_addr_i, lane0_rs2_addr_i, lane0_rs1_addr_i}),
        .rd_data_o (rf_rd_data),
        .we_i      ({mem1_fwd_we_i, mem0_fwd_we_i}),
        .wr_addr_i ({mem1_fwd_addr_i, mem0_fwd_addr_i}),
        .wr_data_i ({mem1_fwd_data_i, mem0_fwd_data_i})
    );

    issue_hazard u_issue_hazard (
        .issue_mask_o (issue_mask),
        .*
    );

    operand_select u_operand_select (
        .lane0_rf_rs1_data_i (rf_rd_data[0]),
        .lane0_rf_rs2_data_i (rf_rd_data[1]),
        .lane1_rf_rs1_data_i (rf_rd_data[2]),
        .lane1_rf_rs2_data_i (rf_rd_data[3]),
        .lane0_op1_o         (lane0_op1),
        .lane0_op2_o         (lane0_op2),
        .lane0_br_flags_o    (lane0_br_flags),
        .lane1_op1_o         (lane1_op1),
        .lane1_op2_o         (lane1_op2),
        .lane1_br_flags_o    (lane1_br_flags),
        .*
    );

    // Remaining lane fields and all outputs connect by name
    dispatch_stage u_dispatch_stage (
        .issue_mask_i     (issue_mask),
        .lane0_op1_i      (lane0_op1),
        .lane0_op2_i      (lane0_op2),
        .lane0_br_flags_i (lane0_br_flags),
        .lane1_op1_i      (lane1_op1),
        .lane1_op2_i      (lane1_op2),
        .lane1_br_flags_i (lane1_br_flags),
        .*
    );

endmodule

`default_nettype wire

/* test/dispatch_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_assertions (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       stall_i,
    input  wire       flush_i,
    input  wire [1:0] accept_i,
    input  wire       out0_valid_i,
    input  wire       out1_valid_i
);

    // Back-pressure holds the output register
    stall_holds_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_i && !flush_i) |=> ($stable(out0_valid_i) && $stable(out1_valid_i)))
        else $error("output valid changed during a stall");

    lane0_accept_to_valid: assert property (@(posedge clk) disable iff (!rst_n)
        accept_i[0] |=> out0_valid_i)
        else $error("lane 0 accepted but out0 valid low one cycle later");

    lane1_accept_to_valid: assert property (@(posedge clk) disable iff (!rst_n)
        accept_i[1] |=> out1_valid_i)
        else $error("lane 1 accepted but out1 valid low one cycle later");

    flush_clears_valid: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> (!out0_valid_i && !out1_valid_i))
        else $error("output valid high in the cycle after a flush");

    // First edge after reset release
    reset_valid_low: assert property (@(posedge clk)
        $rose(rst_n) |-> (!out0_valid_i && !out1_valid_i))
        else $error("output valid high right after reset");

endmodule

`default_nettype wire

/* test/dispatch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_tb
    import isa_pkg::*;
    import dispatch_pkg::*;
;

    localparam int NUM_CYCLES     = 2000;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = 2100;

    logic clk;
    logic rst_n;
    logic stall;
    logic flush;

    // Lane inputs indexed by lane
    logic      in_valid [2];
    reg_addr_t in_rs1_addr [2];
    logic      in_rs1_rd [2];
    reg_addr_t in_rs2_addr [2];
    logic      in_rs2_rd [2];
    reg_addr_t in_rd_addr [2];
    logic      in_rd_we [2];
    alu_op_t   in_alu_op [2];
    logic      in_use_imm [2];
    imm_t      in_imm [2];

    // Forwarding sources in priority order ex1, ex0, mem1, mem0
    logic      fwd_we [4];
    reg_addr_t fwd_addr [4];
    reg_data_t fwd_data [4];

    logic [1:0]    accept;
    logic          out_valid [2];
    alu_op_t       out_alu_op [2];
    reg_addr_t     out_rd_addr [2];
    logic          out_rd_we [2];
    reg_data_t     out_op1 [2];
    reg_data_t     out_op2 [2];
    imm_t          out_imm [2];
    branch_flags_t out_flags [2];

    // Reference model state
    reg_data_t     model_regs [32];
    logic          exp_valid [2];
    alu_op_t       exp_alu_op [2];
    reg_addr_t     exp_rd_addr [2];
    logic          exp_rd_we [2];
    reg_data_t     exp_op1 [2];
    reg_data_t     exp_op2 [2];
    imm_t          exp_imm [2];
    branch_flags_t exp_flags [2];

    int cycle_count = 0;

    dispatch_top #(
        .NUM_REGS (32)
    ) u_dispatch_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .lane0_valid_i    (in_valid[0]),
        .lane0_rs1_addr_i (in_rs1_addr[0]),
        .lane0_rs1_rd_i   (in_rs1_rd[0]),
        .lane0_rs2_addr_i (in_rs2_addr[0]),
        .lane0_rs2_rd_i   (in_rs2_rd[0]),
        .lane0_rd_addr_i  (in_rd_addr[0]),
        .lane0_rd_we_i    (in_rd_we[0]),
        .lane0_alu_op_i   (in_alu_op[0]),
        .lane0_use_imm_i  (in_use_imm[0]),
        .lane0_imm_i      (in_imm[0]),
        .lane1_valid_i    (in_valid[1]),
        .lane1_rs1_addr_i (in_rs1_addr[1]),
        .lane1_rs1_rd_i   (in_rs1_rd[1]),
        .lane1_rs2_addr_i (in_rs2_addr[1]),
        .lane1_rs2_rd_i   (in_rs2_rd[1]),
        .lane1_rd_addr_i  (in_rd_addr[1]),
        .lane1_rd_we_i    (in_rd_we[1]),
        .lane1_alu_op_i   (in_alu_op[1]),
        .lane1_use_imm_i  (in_use_imm[1]),
        .lane1_imm_i      (in_imm[1]),
        .ex1_fwd_we_i     (fwd_we[0]),
        .ex1_fwd_addr_i   (fwd_addr[0]),
        .ex1_fwd_data_i   (fwd_data[0]),
        .ex0_fwd_we_i     (fwd_we[1]),
        .ex0_fwd_addr_i   (fwd_addr[1]),
        .ex0_fwd_data_i   (fwd_data[1]),
        .mem1_fwd_we_i    (fwd_we[2]),
        .mem1_fwd_addr_i  (fwd_addr[2]),
        .mem1_fwd_data_i  (fwd_data[2]),
        .mem0_fwd_we_i    (fwd_we[3]),
        .mem0_fwd_addr_i  (fwd_addr[3]),
        .mem0_fwd_data_i  (fwd_data[3]),
        .stall_i          (stall),
        .flush_i          (flush),
        .accept_o         (accept),
        .out0_valid_o     (out_valid[0]),
        .out0_alu_op_o    (out_alu_op[0]),
        .out0_rd_addr_o   (out_rd_addr[0]),
        .out0_rd_we_o     (out_rd_we[0]),
        .out0_op1_o       (out_op1[0]),
        .out0_op2_o       (out_op2[0]),
        .out0_imm_o       (out_imm[0]),
        .out0_br_flags_o  (out_flags[0]),
        .out1_valid_o     (out_valid[1]),
        .out1_alu_op_o    (out_alu_op[1]),
        .out1_rd_addr_o   (out_rd_addr[1]),
        .out1_rd_we_o     (out_rd_we[1]),
        .out1_op1_o       (out_op1[1]),
        .out1_op2_o       (out_op2[1]),
        .out1_imm_o       (out_imm[1]),
        .out1_br_flags_o  (out_flags[1])
    );

    bind dispatch_stage dispatch_assertions u_dispatch_assertions (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .accept_i     (accept_o),
        .out0_valid_i (out0_valid_o),
        .out1_valid_i (out1_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            $display("Checks failed");
            $fatal(1, "stopping on timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s actual=0x%0h expected=0x%0h", name, actual, expected);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic reg_addr_t rand_addr();
        // Small address range keeps hazards and forwarding hits frequent
        return reg_addr_t'($urandom_range(7, 0));
    endfunction

    function automatic logic rand_bit();
        return $urandom_range(1, 0) == 1;
    endfunction

    // First matching forwarding source wins over the model register
    function automatic reg_data_t expect_operand(input reg_addr_t addr, input logic en);
        reg_data_t v;
        logic      found;
        v = model_regs[addr];
        found = 1'b0;
        if (en && addr != '0) begin
            for (int s = 0; s < 4; s++) begin
                if (!found && fwd_we[s] && fwd_addr[s] == addr) begin
                    v = fwd_data[s];
                    found = 1'b1;
                end
            end
        end
        return v;
    endfunction

    function automatic branch_flags_t expect_flags(input reg_data_t a, input reg_data_t b);
        branch_flags_t f;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        f[BR_EQ]  = (a == b);
        f[BR_NE]  = !(a == b);
        f[BR_LT]  = (sa < sb);
        f[BR_GE]  = !(sa < sb);
        f[BR_LTU] = (a < b);
        f[BR_GEU] = !(a < b);
        return f;
    endfunction

    function automatic logic [1:0] expect_accept();
        logic       hazard;
        logic [1:0] acc;
        hazard = in_rd_we[0] &&
                 ((in_rs1_rd[1] && in_rs1_addr[1] == in_rd_addr[0]) ||
                  (in_rs2_rd[1] && in_rs2_addr[1] == in_rd_addr[0]));
        acc[0] = in_valid[0] && !stall && !flush;
        acc[1] = in_valid[1] && !hazard && !stall && !flush;
        return acc;
    endfunction

    task automatic clear_lane(input int n);
        exp_valid[n]   = 1'b0;
        exp_alu_op[n]  = '0;
        exp_rd_addr[n] = '0;
        exp_rd_we[n]   = 1'b0;
        exp_op1[n]     = '0;
        exp_op2[n]     = '0;
        exp_imm[n]     = '0;
        exp_flags[n]   = '0;
    endtask

    task automatic check_outputs();
        for (int n = 0; n < 2; n++) begin
            check_value($sformatf("out%0d_valid_o", n), 32'(out_valid[n]), 32'(exp_valid[n]));
            check_value($sformatf("out%0d_alu_op_o", n), 32'(out_alu_op[n]),
                        32'(exp_alu_op[n]));
            check_value($sformatf("out%0d_rd_addr_o", n), 32'(out_rd_addr[n]),
                        32'(exp_rd_addr[n]));
            check_value($sformatf("out%0d_rd_we_o", n), 32'(out_rd_we[n]), 32'(exp_rd_we[n]));
            check_value($sformatf("out%0d_op1_o", n), out_op1[n], exp_op1[n]);
            check_value($sformatf("out%0d_op2_o", n), out_op2[n], exp_op2[n]);
            check_value($sformatf("out%0d_imm_o", n), out_imm[n], exp_imm[n]);
            check_value($sformatf("out%0d_br_flags_o", n), 32'(out_flags[n]),
                        32'(exp_flags[n]));
        end
    endtask

    // State that the coming rising edge produces
    task automatic update_model(input logic [1:0] acc);
        reg_data_t rs1_val;
        reg_data_t rs2_val;
        for (int n = 0; n < 2; n++) begin
            if (flush || (!stall && !acc[n])) begin
                clear_lane(n);
            end else if (!stall) begin
                rs1_val        = expect_operand(in_rs1_addr[n], in_rs1_rd[n]);
                rs2_val        = expect_operand(in_rs2_addr[n], in_rs2_rd[n]);
                exp_valid[n]   = 1'b1;
                exp_alu_op[n]  = in_alu_op[n];
                exp_rd_addr[n] = in_rd_addr[n];
                exp_rd_we[n]   = in_rd_we[n];
                exp_op1[n]     = rs1_val;
                exp_op2[n]     = in_use_imm[n] ? in_imm[n] : rs2_val;
                exp_imm[n]     = in_imm[n];
                exp_flags[n]   = expect_flags(rs1_val, rs2_val);
            end
        end
        // Writeback with mem1 applied second so it wins a collision
        if (fwd_we[3] && fwd_addr[3] != '0) begin
            model_regs[fwd_addr[3]] = fwd_data[3];
        end
        if (fwd_we[2] && fwd_addr[2] != '0) begin
            model_regs[fwd_addr[2]] = fwd_data[2];
        end
    endtask

    task automatic drive_random_inputs();
        for (int n = 0; n < 2; n++) begin
            in_valid[n]    <= ($urandom_range(3, 0) != 0);
            in_rs1_addr[n] <= rand_addr();
            in_rs1_rd[n]   <= rand_bit();
            in_rs2_addr[n] <= rand_addr();
            in_rs2_rd[n]   <= rand_bit();
            in_rd_addr[n]  <= rand_addr();
            in_rd_we[n]    <= rand_bit();
            in_alu_op[n]   <= alu_op_t'($urandom);
            in_use_imm[n]  <= rand_bit();
            in_imm[n]      <= $urandom;
        end
        for (int s = 0; s < 4; s++) begin
            fwd_we[s]   <= rand_bit();
            fwd_addr[s] <= rand_addr();
            fwd_data[s] <= $urandom;
        end
        stall <= ($urandom_range(99, 0) < 15);
        flush <= ($urandom_range(99, 0) < 5);
    endtask

    initial begin
        logic [1:0] acc;
        void'($urandom(32'ha3a0_5b66));
        rst_n <= 1'b0;
        stall <= 1'b0;
        flush <= 1'b0;
        for (int n = 0; n < 2; n++) begin
            in_valid[n]    <= 1'b0;
            in_rs1_addr[n] <= '0;
            in_rs1_rd[n]   <= 1'b0;
            in_rs2_addr[n] <= '0;
            in_rs2_rd[n]   <= 1'b0;
            in_rd_addr[n]  <= '0;
            in_rd_we[n]    <= 1'b0;
            in_alu_op[n]   <= '0;
            in_use_imm[n]  <= 1'b0;
            in_imm[n]      <= '0;
            clear_lane(n);
        end
        for (int s = 0; s < 4; s++) begin
            fwd_we[s]   <= 1'b0;
            fwd_addr[s] <= '0;
            fwd_data[s] <= '0;
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int c = 0; c < NUM_CYCLES; c++) begin
            // Inputs and outputs are settled mid-cycle
            @(negedge clk);
            acc = expect_accept();
            check_value("accept_o", 32'(accept), 32'(acc));
            check_outputs();
            update_model(acc);
            @(posedge clk);
            drive_random_inputs();
        end

        @(negedge clk);
        check_outputs();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
source/isa_pkg.sv
source/dispatch_pkg.sv
source/register_file.sv
source/issue_hazard.sv
source/operand_select.sv
source/dispatch_stage.sv
source/dispatch_top.sv
test/dispatch_assertions.sv
test/dispatch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the dispatch testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module dispatch_tb -f compile.f -o dispatch_sim > build.log 2>&1 \
    || { cat build.log; echo "FAIL: build error"; exit 1; }

./obj_dir/dispatch_sim > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All checks passed" sim.log && { echo "PASS"; exit 0; }
echo "FAIL: simulation ended without a result"
exit 1
